// File: rtl/lcd_pkg.sv
package lcd_pkg;

	typedef logic [6:0]  lcd_cfg_t;   // lines, font, display, cursor, blink, inc_dec, shift
	typedef logic [9:0]  lcd_cmd_t;   // rs, rw, data[7:0]
	typedef logic [7:0]  lcd_byte_t;
	typedef logic [3:0]  axi_addr_t;
	typedef logic [31:0] axi_data_t;
	typedef logic [1:0]  axi_resp_t;

	// bit positions inside lcd_cfg_t
	localparam int CFG_LINES   = 6;
	localparam int CFG_FONT    = 5;
	localparam int CFG_DISPLAY = 4;
	localparam int CFG_CURSOR  = 3;
	localparam int CFG_BLINK   = 2;
	localparam int CFG_INC_DEC = 1;
	localparam int CFG_SHIFT   = 0;

	localparam int CMD_RS = 9;
	localparam int CMD_RW = 8;

	localparam axi_addr_t REG_CONFIG = 4'h0;
	localparam axi_addr_t REG_CTRL   = 4'h4;
	localparam axi_addr_t REG_DATA   = 4'h8;
	localparam axi_addr_t REG_STATUS = 4'hC;

	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	// timing, in microseconds
	localparam int T_POWERUP_US    = 500;
	localparam int T_PULSE_US      = 10;   // enable high for init commands
	localparam int T_WAIT_SHORT_US = 50;
	localparam int T_WAIT_CLEAR_US = 200;
	localparam int T_WAIT_ENTRY_US = 100;
	localparam int T_WR_SETUP_US   = 1;
	localparam int T_WR_HIGH_US    = 13;
	localparam int T_WR_TOTAL_US   = 50;

endpackage

// File: rtl/lcd_regs.sv
`timescale 1ns/1ps

module lcd_regs #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                        clk,
	input  logic                        arst_n,
	input  lcd_pkg::axi_addr_t          awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  lcd_pkg::axi_data_t          wdata,
	input  logic [3:0]                  wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output lcd_pkg::axi_resp_t          bresp,
	output logic                        bvalid,
	input  logic                        bready,
	input  lcd_pkg::axi_addr_t          araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output lcd_pkg::axi_data_t          rdata,
	output lcd_pkg::axi_resp_t          rresp,
	output logic                        rvalid,
	input  logic                        rready,
	output lcd_pkg::lcd_cfg_t           cfg,
	output logic                        start,
	output logic                        push,
	output lcd_pkg::lcd_cmd_t           push_data,
	input  logic                        full,
	input  logic                        empty,
	input  logic [$clog2(FIFO_DEPTH):0] level,
	input  logic                        init_done,
	input  logic                        busy
);

	logic               wr_go;
	logic               wr_hs;
	logic               wr_err;
	logic               rd_hs;
	lcd_pkg::axi_data_t rd_mux;

	// accept AW and W together, only with no response outstanding
	assign wr_go = awvalid && wvalid && !bvalid && !awready;
	assign wr_hs = awvalid && awready && wvalid && wready;
	assign rd_hs = arvalid && arready;

	assign rresp = lcd_pkg::RESP_OKAY; // reads never fail

	always_comb begin
		case (awaddr)
			lcd_pkg::REG_CONFIG,
			lcd_pkg::REG_CTRL,
			lcd_pkg::REG_STATUS: wr_err = 1'b0; // status write is dropped quietly
			lcd_pkg::REG_DATA:   wr_err = full;
			default:             wr_err = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			bresp   <= lcd_pkg::RESP_OKAY;
		end else begin
			awready <= wr_go;
			wready  <= wr_go;
			if (wr_hs) begin
				bvalid <= 1'b1;
				bresp  <= wr_err ? lcd_pkg::RESP_SLVERR : lcd_pkg::RESP_OKAY;
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg   <= '0;
			start <= 1'b0;
			push  <= 1'b0;
		end else begin
			start <= 1'b0; // single cycle pulses
			push  <= 1'b0;
			if (wr_hs && !wr_err && wstrb[0]) begin
				case (awaddr)
					lcd_pkg::REG_CONFIG: cfg   <= wdata[6:0];
					lcd_pkg::REG_CTRL:   start <= wdata[0];
					lcd_pkg::REG_DATA:   push  <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_hs && awaddr == lcd_pkg::REG_DATA)
			push_data <= wdata[9:0];
	end

	always_comb begin
		rd_mux = '0;
		case (araddr)
			lcd_pkg::REG_CONFIG: rd_mux[6:0] = cfg;
			lcd_pkg::REG_STATUS: begin
				rd_mux[0]    = init_done;
				rd_mux[1]    = busy;
				rd_mux[2]    = full;
				rd_mux[3]    = empty;
				rd_mux[11:8] = 4'(level);
			end
			default: ; // ctrl, data and holes read as zero
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			arready <= arvalid && !rvalid && !arready;
			if (rd_hs)
				rvalid <= 1'b1;
			else if (rvalid && rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_hs)
			rdata <= rd_mux; // live status sampled at the handshake
	end

	a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
		bvalid && !bready |=> bvalid);

endmodule

// File: rtl/lcd_cmd_fifo.sv
`timescale 1ns/1ps

module lcd_cmd_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        push,
	input  lcd_pkg::lcd_cmd_t           push_data,
	input  logic                        pop,
	output lcd_pkg::lcd_cmd_t           cmd,
	output logic                        full,
	output logic                        empty,
	output logic [$clog2(FIFO_DEPTH):0] level
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [PTR_W:0]   lvl_t;

	localparam lvl_t LVL_FULL = lvl_t'(FIFO_DEPTH);

	lcd_pkg::lcd_cmd_t mem [FIFO_DEPTH];
	ptr_t              wr_ptr;
	ptr_t              rd_ptr;
	logic              do_push;
	logic              do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign full  = (level == LVL_FULL);
	assign empty = (level == '0);
	assign cmd   = mem[rd_ptr]; // head word, valid when not empty

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, wraps itself
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: ; // both or neither keep the level
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
		push |-> !full);

	a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
		pop |-> !empty);

endmodule

// File: rtl/lcd_controller.sv
`timescale 1ns/1ps

module lcd_controller #(
	parameter int CYCLES_PER_US = 10
) (
	input  logic               clk,
	input  logic               arst_n,
	input  lcd_pkg::lcd_cfg_t  cfg,
	input  logic               start,
	input  logic               empty,
	input  lcd_pkg::lcd_cmd_t  cmd,
	output logic               pop,
	output logic               e,
	output logic               rs,
	output logic               rw,
	output lcd_pkg::lcd_byte_t lcd_data,
	output logic               busy,
	output logic               init_done
);

	localparam int N        = CYCLES_PER_US;
	localparam int PWR_END  = lcd_pkg::T_POWERUP_US * N; // longest interval
	localparam int CNT_W    = $clog2(PWR_END + 1);
	localparam int PULSE    = lcd_pkg::T_PULSE_US * N;

	// init step boundaries counted from the first function set cycle
	localparam int FS_END   = PULSE;
	localparam int FS_GAP   = FS_END + lcd_pkg::T_WAIT_SHORT_US * N;
	localparam int DC_END   = FS_GAP + PULSE;
	localparam int DC_GAP   = DC_END + lcd_pkg::T_WAIT_SHORT_US * N;
	localparam int CL_END   = DC_GAP + PULSE;
	localparam int CL_GAP   = CL_END + lcd_pkg::T_WAIT_CLEAR_US * N;
	localparam int EM_END   = CL_GAP + PULSE;
	localparam int INIT_END = EM_END + lcd_pkg::T_WAIT_ENTRY_US * N;

	// write cycle enable window
	localparam int WR_E_ON  = lcd_pkg::T_WR_SETUP_US * N;
	localparam int WR_E_OFF = WR_E_ON + lcd_pkg::T_WR_HIGH_US * N;
	localparam int WR_END   = lcd_pkg::T_WR_TOTAL_US * N;

	typedef logic [CNT_W-1:0] cnt_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_POWERUP,
		ST_INIT,
		ST_READY,
		ST_WRITE
	} state_t;

	state_t     state;
	cnt_t       cnt;
	cnt_t       cnt_nxt;
	logic [8:0] init_nxt;

	// {e, data} for a given cycle of the init sequence
	function automatic logic [8:0] init_pins(input int k, input lcd_pkg::lcd_cfg_t c);
		logic [8:0] p;
		p = '0;
		if (k < FS_END)
			p = {1'b1, 4'b0011, c[lcd_pkg::CFG_LINES], c[lcd_pkg::CFG_FONT], 2'b00};
		else if (k >= FS_GAP && k < DC_END)
			p = {1'b1, 5'b00001, c[lcd_pkg::CFG_DISPLAY], c[lcd_pkg::CFG_CURSOR],
				c[lcd_pkg::CFG_BLINK]};
		else if (k >= DC_GAP && k < CL_END)
			p = {1'b1, 8'h01}; // clear display
		else if (k >= CL_GAP && k < EM_END)
			p = {1'b1, 6'b000001, c[lcd_pkg::CFG_INC_DEC], c[lcd_pkg::CFG_SHIFT]};
		return p;
	endfunction

	assign cnt_nxt  = cnt + 1'b1;
	assign init_nxt = init_pins(int'(cnt_nxt), cfg);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_IDLE;
			cnt       <= '0;
			pop       <= 1'b0;
			e         <= 1'b0;
			rs        <= 1'b0;
			rw        <= 1'b0;
			lcd_data  <= '0;
			busy      <= 1'b0;
			init_done <= 1'b0;
		end else begin
			pop <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start) begin
						state <= ST_POWERUP;
						cnt   <= '0;
						busy  <= 1'b1;
					end
				end
				ST_POWERUP: begin
					if (cnt == cnt_t'(PWR_END - 1)) begin
						state           <= ST_INIT;
						cnt             <= '0;
						{e, lcd_data}   <= init_pins(0, cfg); // function set goes out now
					end else begin
						cnt <= cnt_nxt;
					end
				end
				ST_INIT: begin
					if (cnt == cnt_t'(INIT_END - 1)) begin
						state     <= ST_READY;
						cnt       <= '0;
						busy      <= 1'b0;
						init_done <= 1'b1; // sticky until reset
						e         <= 1'b0;
						lcd_data  <= '0;
					end else begin
						cnt           <= cnt_nxt;
						{e, lcd_data} <= init_nxt;
					end
				end
				ST_READY: begin
					if (!empty) begin
						state    <= ST_WRITE;
						pop      <= 1'b1;
						cnt      <= '0;
						busy     <= 1'b1;
						rs       <= cmd[lcd_pkg::CMD_RS];
						rw       <= cmd[lcd_pkg::CMD_RW];
						lcd_data <= cmd[7:0];
					end
				end
				ST_WRITE: begin
					if (cnt == cnt_t'(WR_END - 1)) begin
						state    <= ST_READY; // one idle cycle before next pop
						cnt      <= '0;
						busy     <= 1'b0;
						e        <= 1'b0;
						rs       <= 1'b0;
						rw       <= 1'b0;
						lcd_data <= '0;
					end else begin
						cnt <= cnt_nxt;
						e   <= (int'(cnt_nxt) >= WR_E_ON) && (int'(cnt_nxt) < WR_E_OFF);
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// bus must not move under a high enable as the LCD latches on its fall
	a_pins_stable: assert property (@(posedge clk) disable iff (!arst_n)
		e && $past(e) |-> $stable({rs, rw, lcd_data}));

	a_pop_ready: assert property (@(posedge clk) disable iff (!arst_n)
		pop |-> !empty && $past(init_done && !busy));

endmodule

// File: rtl/lcd_subsys.sv
`timescale 1ns/1ps

module lcd_subsys #(
	parameter int CYCLES_PER_US = 10,
	parameter int FIFO_DEPTH    = 8   // power of two
) (
	input  logic               clk,
	input  logic               arst_n,
	input  lcd_pkg::axi_addr_t awaddr,
	input  logic               awvalid,
	output logic               awready,
	input  lcd_pkg::axi_data_t wdata,
	input  logic [3:0]         wstrb,
	input  logic               wvalid,
	output logic               wready,
	output lcd_pkg::axi_resp_t bresp,
	output logic               bvalid,
	input  logic               bready,
	input  lcd_pkg::axi_addr_t araddr,
	input  logic               arvalid,
	output logic               arready,
	output lcd_pkg::axi_data_t rdata,
	output lcd_pkg::axi_resp_t rresp,
	output logic               rvalid,
	input  logic               rready,
	output logic               e,
	output logic               rs,
	output logic               rw,
	output lcd_pkg::lcd_byte_t lcd_data
);

	lcd_pkg::lcd_cfg_t           cfg;
	logic                        start;
	logic                        push;
	lcd_pkg::lcd_cmd_t           push_data;
	logic                        pop;
	lcd_pkg::lcd_cmd_t           cmd;
	logic                        full;
	logic                        empty;
	logic [$clog2(FIFO_DEPTH):0] level;
	logic                        init_done;
	logic                        busy;

	lcd_regs #(.FIFO_DEPTH(FIFO_DEPTH)) i_regs (
		.clk, .arst_n,
		.awaddr, .awvalid, .awready,
		.wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.cfg, .start, .push, .push_data,
		.full, .empty, .level,
		.init_done, .busy
	);

	lcd_cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo (
		.clk, .arst_n,
		.push, .push_data,
		.pop, .cmd,
		.full, .empty, .level
	);

	lcd_controller #(.CYCLES_PER_US(CYCLES_PER_US)) i_ctrl (
		.clk, .arst_n,
		.cfg, .start,
		.empty, .cmd, .pop,
		.e, .rs, .rw, .lcd_data,
		.busy, .init_done
	);

endmodule

// File: testbench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic arst_n
);

	localparam int HALF_PERIOD  = 10; // 20 ns clock
	localparam int RESET_CYCLES = 2;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1; // release away from the active edge
	end

endmodule

// File: testbench/tb_lcd_subsys.sv
`timescale 1ns/1ps

module tb_lcd_subsys;

	localparam int N_US        = 2;
	localparam int FIFO_DEPTH  = 4;
	localparam int INIT_HIGH   = 10 * N_US;
	localparam int GAP_SHORT   = 50 * N_US;
	localparam int GAP_CLEAR   = 200 * N_US;
	localparam int GAP_ENTRY   = 100 * N_US;
	localparam int WR_SETUP    = 1 * N_US;
	localparam int WR_HIGH     = 13 * N_US;
	localparam int WORD_CYCLES = 51 * N_US;
	localparam int WORDS       = 2 + 3 + FIFO_DEPTH + 1;
	localparam int INIT_CYCLES = (500 + 4 * 10 + 50 + 50 + 200 + 100) * N_US;
	localparam int WD_CYCLES   = 2 * (INIT_CYCLES + WORDS * WORD_CYCLES);

	logic               clk, arst_n;
	lcd_pkg::axi_addr_t awaddr, araddr;
	lcd_pkg::axi_data_t wdata, rdata;
	lcd_pkg::axi_resp_t bresp, rresp;
	logic [3:0]         wstrb;
	logic               awvalid, awready, wvalid, wready, bvalid, bready;
	logic               arvalid, arready, rvalid, rready;
	logic               e, rs, rw;
	lcd_pkg::lcd_byte_t lcd_data;
	logic [9:0]         pins;
	logic [31:0]        lcg_state;
	logic               started;      // set just before the start pulse
	logic               e_q;
	int                 hi_cnt, lo_cnt, n_rises;
	logic [9:0]         seen [$];     // {rs, rw, data} at each enable rise
	logic [9:0]         exp_words [$];
	int                 errors, tests_passed, tests_failed;

	assign pins = {rs, rw, lcd_data};

	tb_clk_gen i_clk_gen (.clk, .arst_n);

	lcd_subsys #(.CYCLES_PER_US(N_US), .FIFO_DEPTH(FIFO_DEPTH)) i_dut (.*);

	// pin monitor
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			e_q     <= 1'b0;
			hi_cnt  <= 0;
			lo_cnt  <= 0;
			n_rises <= 0;
		end else begin
			e_q    <= e;
			hi_cnt <= e ? hi_cnt + 1 : 0;
			lo_cnt <= e ? 0 : lo_cnt + 1;
			if (e && !e_q) begin
				n_rises <= n_rises + 1;
				seen.push_back(pins);
			end
		end
	end

	a_idle_before_start: assert property (@(posedge clk) disable iff (!arst_n)
		!started |-> !e && pins == '0)
		else report_fail("LCD pins moved before start");

	a_pins_stable: assert property (@(posedge clk) disable iff (!arst_n)
		e && $past(e) |-> $stable(pins))
		else report_fail("rs, rw or data changed while e was high");

	// first four pulses are the init commands
	a_high_time: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(e) |-> hi_cnt == ((n_rises <= 4) ? INIT_HIGH : WR_HIGH))
		else report_fail($sformatf("pulse %0d high for %0d cycles",
			$sampled(n_rises), $sampled(hi_cnt)));

	a_init_gap: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(e) && n_rises inside {1, 2, 3} |->
			lo_cnt == ((n_rises == 3) ? GAP_CLEAR : GAP_SHORT))
		else report_fail($sformatf("gap before pulse %0d is %0d cycles",
			$sampled(n_rises) + 1, $sampled(lo_cnt)));

	a_entry_wait: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(e) && n_rises == 4 |-> lo_cnt >= GAP_ENTRY)
		else report_fail("first write pulse inside the entry mode wait");

	// enable rises 1 us after the word that follows an idle cycle
	a_write_setup: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(e) && n_rises >= 4 |-> $past(pins) == pins &&
			$past(pins, WR_SETUP) == pins && $past(pins, WR_SETUP + 1) == '0)
		else report_fail("write enable does not rise 1 us after the word");

	task automatic report_fail(input string msg);
		errors++;
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR at %0t ns: %s", $time, msg);
	endtask

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic axi_write(input lcd_pkg::axi_addr_t addr, input lcd_pkg::axi_data_t data,
			output lcd_pkg::axi_resp_t resp);
		@(negedge clk);
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		do @(negedge clk); while (!(awready && wready));
		@(negedge clk); // handshake took place on the edge before
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (!bvalid) @(negedge clk);
		@(negedge clk); // response held back for one cycle
		resp   = bresp;
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input lcd_pkg::axi_addr_t addr, output lcd_pkg::axi_data_t data);
		@(negedge clk);
		araddr  = addr;
		arvalid = 1'b1;
		rready  = 1'b1;
		do @(negedge clk); while (!arready);
		@(negedge clk);
		arvalid = 1'b0;
		while (!rvalid) @(negedge clk);
		data = rdata;
		assert (rresp == lcd_pkg::RESP_OKAY)
			else report_fail($sformatf("read response %b, expected OKAY", rresp));
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic write_word();
		logic [31:0]        rnd;
		lcd_pkg::axi_resp_t resp;
		rnd = next_random();
		axi_write(lcd_pkg::REG_DATA, {22'h0, rnd[25:16]}, resp);
		assert (resp == lcd_pkg::RESP_OKAY) else report_fail("REG_DATA write refused");
		exp_words.push_back(rnd[25:16]);
	endtask

	task automatic wait_pulses(input int count, input int limit);
		int waited;
		waited = 0;
		while (seen.size() < count && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (seen.size() < count)
			report_error($sformatf("only %0d of %0d enable pulses came within %0d cycles",
				seen.size(), count, limit));
	endtask

	task automatic wait_status(input logic [31:0] mask, input logic [31:0] value, input int polls);
		lcd_pkg::axi_data_t rd;
		int                 n;
		n = 0;
		do begin
			axi_read(lcd_pkg::REG_STATUS, rd);
			n++;
		end while ((rd & mask) != value && n < polls);
		if ((rd & mask) != value)
			report_error($sformatf("status never reached %h, last read %h", value, rd));
	endtask

	task automatic check_words();
		assert (seen.size() == exp_words.size() + 4)
			else report_fail($sformatf("%0d enable pulses, expected %0d",
				seen.size(), exp_words.size() + 4));
		for (int i = 0; i < exp_words.size() && i + 4 < seen.size(); i++)
			assert (seen[i + 4] == exp_words[i])
				else report_fail($sformatf("word %0d on pins is %h, expected %h",
					i, seen[i + 4], exp_words[i]));
	endtask

	task automatic finish_test(input string name, input int err_mark);
		if (errors == err_mark) begin
			tests_passed++;
			$display("test %s passed", name);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", name, errors - err_mark);
		end
	endtask

	initial begin
		repeat (WD_CYCLES) @(posedge clk);
		$display("ERROR: watchdog expired after %0d cycles, the run hung", WD_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		lcd_pkg::axi_data_t rd;
		lcd_pkg::axi_resp_t resp;
		logic [31:0]        rnd;
		lcd_pkg::lcd_cfg_t  cfg_val;
		logic [7:0]         exp_init [4];
		int                 err_mark;
		lcg_state = 32'h706d_4786;
		{awaddr, araddr, wdata, wstrb} = '0;
		{awvalid, wvalid, bready, arvalid, rready} = '0;
		wstrb   = 4'hF;
		started = 1'b0;
		{errors, tests_passed, tests_failed} = '0;
		@(posedge arst_n);
		@(negedge clk);

		err_mark = errors;
		assert (pins == '0 && !e) else report_fail("LCD pins not idle after reset");
		axi_read(lcd_pkg::REG_STATUS, rd);
		assert (rd == 32'h0000_0008) else report_fail($sformatf("status after reset %h", rd));
		repeat (20) @(negedge clk); // idle window for the no-pulse check
		finish_test("reset_idle", err_mark);

		err_mark = errors;
		rnd     = next_random();
		cfg_val = rnd[22:16];
		axi_write(lcd_pkg::REG_CONFIG, 32'(cfg_val), resp);
		started = 1'b1;
		axi_write(lcd_pkg::REG_CTRL, 32'h1, resp);
		write_word(); // queued before init_done
		write_word();
		exp_init[0] = {4'b0011, cfg_val[6:5], 2'b00};
		exp_init[1] = {5'b00001, cfg_val[4:2]};
		exp_init[2] = 8'h01;
		exp_init[3] = {6'b000001, cfg_val[1:0]};
		wait_pulses(4, INIT_CYCLES + 100);
		for (int i = 0; i < 4 && i < seen.size(); i++)
			assert (seen[i] == {2'b00, exp_init[i]})
				else report_fail($sformatf("init byte %0d is %h, expected %h",
					i, seen[i], exp_init[i]));
		while (e) @(negedge clk);
		axi_read(lcd_pkg::REG_STATUS, rd);
		assert (!rd[0]) else report_fail("init_done set before the entry mode wait ended");
		wait_status(32'h1, 32'h1, 100);
		finish_test("init_sequence", err_mark);

		err_mark = errors;
		for (int i = 0; i < 3; i++)
			write_word();
		wait_pulses(4 + exp_words.size(), (exp_words.size() + 1) * WORD_CYCLES);
		check_words();
		finish_test("write_order", err_mark);

		err_mark = errors;
		wait_status(32'hA, 32'h8, 200); // controller idle with an empty queue
		write_word();
		wait_status(32'hA, 32'hA, 20); // word popped and controller busy
		for (int i = 0; i < FIFO_DEPTH; i++)
			write_word();
		axi_read(lcd_pkg::REG_STATUS, rd);
		assert (rd == (32'h7 | (32'(FIFO_DEPTH) << 8)))
			else report_fail($sformatf("status with full queue %h", rd));
		rnd = next_random();
		axi_write(lcd_pkg::REG_DATA, {22'h0, rnd[25:16]}, resp);
		assert (resp == lcd_pkg::RESP_SLVERR) else report_fail("write to full queue accepted");
		wait_pulses(4 + exp_words.size(), (FIFO_DEPTH + 2) * WORD_CYCLES);
		wait_status(32'hA, 32'h8, 200);
		check_words();
		finish_test("back_pressure", err_mark);

		err_mark = errors;
		rnd = next_random();
		axi_write(lcd_pkg::REG_CONFIG, rnd, resp);
		axi_read(lcd_pkg::REG_CONFIG, rd);
		assert (resp == lcd_pkg::RESP_OKAY && rd == {25'h0, rnd[6:0]})
			else report_fail($sformatf("REG_CONFIG reads %h", rd));
		axi_write(4'h6, next_random(), resp);
		assert (resp == lcd_pkg::RESP_SLVERR) else report_fail("unmapped write returned OKAY");
		axi_read(lcd_pkg::REG_CONFIG, rd);
		assert (rd == {25'h0, rnd[6:0]}) else report_fail("unmapped write changed REG_CONFIG");
		axi_read(lcd_pkg::REG_CTRL, rd);
		assert (rd == '0) else report_fail($sformatf("REG_CTRL reads %h", rd));
		finish_test("register_access", err_mark);

		$display("tests passed: %0d, tests failed: %0d, failed checks: %0d",
			tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: lcd_subsys.f
rtl/lcd_pkg.sv
rtl/lcd_regs.sv
rtl/lcd_cmd_fifo.sv
rtl/lcd_controller.sv
rtl/lcd_subsys.sv
testbench/tb_clk_gen.sv
testbench/tb_lcd_subsys.sv

// File: Bender.yml
package:
  name: lcd_subsys

sources:
  - rtl/lcd_pkg.sv
  - rtl/lcd_regs.sv
  - rtl/lcd_cmd_fifo.sv
  - rtl/lcd_controller.sv
  - rtl/lcd_subsys.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_lcd_subsys.sv
